// ==== verilog/mem_bus_config.svh ====
// Bus sizing macros: code burst length, DMA address width, read burst maximum
`ifndef MEM_BUS_CONFIG_SVH
`define MEM_BUS_CONFIG_SVH

// ------------------------------
// Code fetch
// ------------------------------

// Dwords per code fetch
// Also the number of words in one code line
`define MEM_CODE_BURST 8

// ------------------------------
// DMA slave
// ------------------------------

// DMA byte address width, 16 MB window
`define MEM_DMA_ADDR_W 24

// ------------------------------
// Data reads
// ------------------------------

// Longest core read burst in dwords
`define MEM_RD_MAX_DW 3

`endif

// ==== verilog/avm_pkg.sv ====
// Avalon-MM field types and byteenable/burstcount constants
`default_nettype none

package avm_pkg;

   // ------------------------------
   // Field types
   // ------------------------------

   // Dword address, byte offset bits dropped
   typedef logic [31:2] avm_addr_t;

   // One data word
   typedef logic [31:0] avm_data_t;

   // One enable bit per byte lane
   typedef logic [3:0] avm_be_t;

   // Beats per command
   typedef logic [3:0] avm_burst_t;

   // ------------------------------
   // Constants
   // ------------------------------

   // All four byte lanes
   localparam avm_be_t AVM_BE_ALL = 4'b1111;

   // Single beat command
   localparam avm_burst_t AVM_BURST_ONE = 4'd1;

endpackage

`default_nettype wire

// ==== verilog/cpu_req_pkg.sv ====
// Core request length types, bridge state encoding, code line type
`default_nettype none

`include "mem_bus_config.svh"

package cpu_req_pkg;

   // ------------------------------
   // Request lengths
   // ------------------------------

   // Length in dwords, 1 to 3
   typedef logic [1:0] dword_len_t;

   // Read length in bytes
   typedef logic [3:0] byte_len_t;

   // ------------------------------
   // Bridge FSM
   // ------------------------------

   // One state per kind of bus transfer in flight
   typedef enum logic [2:0] {
      IDLE      = 3'd0,
      WRITE     = 3'd1,
      READ      = 3'd2,
      READ_CODE = 3'd3,
      WRITE_DMA = 3'd4,
      READ_DMA  = 3'd5
   } mem_state_t;

   // Whole code line, word 0 in the low bits
   typedef avm_pkg::avm_data_t [`MEM_CODE_BURST-1:0] code_line_t;

endpackage

`default_nettype wire

// ==== verilog/avalon_mem.sv ====
// Bridge from core write/read/code requests and DMA slave to one Avalon-MM master
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_config.svh"

module avalon_mem (
   input  logic                          clk,
   input  logic                          rst_n,

   // Core write burst, 1 or 2 dwords
   input  logic                          writeburst_do,
   output logic                          writeburst_done,
   input  logic [31:0]                   writeburst_address,
   input  cpu_req_pkg::dword_len_t       writeburst_dword_length,
   input  avm_pkg::avm_be_t              writeburst_byteenable_0,
   input  avm_pkg::avm_be_t              writeburst_byteenable_1,
   input  logic [55:0]                   writeburst_data,

   // Core read burst, 1 to 3 dwords
   input  logic                          readburst_do,
   output logic                          readburst_done,
   input  logic [31:0]                   readburst_address,
   input  cpu_req_pkg::dword_len_t       readburst_dword_length,
   input  cpu_req_pkg::byte_len_t        readburst_byte_length,
   output logic [32*`MEM_RD_MAX_DW-1:0]  readburst_data,

   // Core code fetch
   input  logic                          readcode_do,
   output logic                          readcode_done,
   input  logic [31:0]                   readcode_address,
   output avm_pkg::avm_data_t            readcode_partial,
   output logic                          readcode_beat,

   // Avalon master
   output avm_pkg::avm_addr_t            avm_address,
   output avm_pkg::avm_data_t            avm_writedata,
   output avm_pkg::avm_be_t              avm_byteenable,
   output avm_pkg::avm_burst_t           avm_burstcount,
   output logic                          avm_write,
   output logic                          avm_read,
   input  logic                          avm_waitrequest,
   input  logic                          avm_readdatavalid,
   input  avm_pkg::avm_data_t            avm_readdata,

   // DMA slave
   input  logic [`MEM_DMA_ADDR_W-1:0]    dma_address,
   input  logic                          dma_write,
   input  avm_pkg::avm_data_t            dma_writedata,
   input  avm_pkg::avm_be_t              dma_byteenable,
   input  logic                          dma_read,
   output avm_pkg::avm_data_t            dma_readdata,
   output logic                          dma_readdatavalid,
   output logic                          dma_waitrequest
);

   import avm_pkg::*;
   import cpu_req_pkg::*;

   // Beat counter wide enough for a code burst
   localparam int CNT_W = $clog2(`MEM_CODE_BURST);

   // ------------------------------
   // Registers
   // ------------------------------

   mem_state_t       state;
   logic [CNT_W-1:0] counter;
   dword_len_t       save_readburst;

   // Second write dword for the WRITE state
   avm_addr_t        writeaddr_next;
   avm_data_t        save_data;
   avm_be_t          byteenable_next;

   // Earlier read beats named by distance from the last beat
   avm_data_t        rd_last_m1;
   avm_data_t        rd_last_m2;

   // ------------------------------
   // Request selection
   // ------------------------------

   logic sel_rd;
   logic sel_code;
   logic dma_start;
   logic sel_dma_wr;
   logic sel_dma_rd;
   logic idle;

   // Fixed priority of write, read, code, then DMA
   assign sel_rd     = ~writeburst_do & readburst_do;
   assign sel_code   = ~writeburst_do & ~readburst_do & readcode_do;
   // DMA only gets the bus with no core request pending
   assign dma_start  = ~(writeburst_do | readburst_do | readcode_do);
   assign sel_dma_wr = dma_start & dma_write;
   assign sel_dma_rd = dma_start & ~dma_write & dma_read;
   assign idle       = (state == IDLE);

   // Read byteenable from byte count and offset
   function automatic avm_be_t read_be(input byte_len_t len, input logic [1:0] off);
      logic [3:0] end_byte;
      logic [3:0] mask;
      end_byte = {2'b00, off} + len;
      // Whole dword for long reads and for reads crossing into the next dword
      if (len == 4'd0 || len >= 4'd4 || end_byte > 4'd4) begin
         return AVM_BE_ALL;
      end
      mask = (4'b0001 << len) - 4'b0001;
      return mask << off;
   endfunction

   // ------------------------------
   // Avalon command
   // ------------------------------

   // Outside IDLE only the second write dword is on the bus
   assign avm_address =
      !idle         ? writeaddr_next :
      writeburst_do ? writeburst_address[31:2] :
      sel_rd        ? readburst_address[31:2] :
      sel_code      ? readcode_address[31:2] :
                      avm_addr_t'(dma_address[`MEM_DMA_ADDR_W-1:2]);

   assign avm_writedata =
      !idle         ? save_data :
      writeburst_do ? writeburst_data[31:0] :
                      dma_writedata;

   // Code fetches read whole dwords
   assign avm_byteenable =
      !idle         ? byteenable_next :
      writeburst_do ? writeburst_byteenable_0 :
      sel_rd        ? read_be(readburst_byte_length, readburst_address[1:0]) :
      sel_code      ? AVM_BE_ALL :
                      dma_byteenable;

   assign avm_burstcount =
      (idle && sel_rd)   ? avm_burst_t'(readburst_dword_length) :
      (idle && sel_code) ? avm_burst_t'(`MEM_CODE_BURST) :
                           AVM_BURST_ONE;

   assign avm_write = (idle && (writeburst_do || sel_dma_wr)) || state == WRITE;
   assign avm_read  = idle && (sel_rd || sel_code || sel_dma_rd);

   // ------------------------------
   // Core and DMA responses
   // ------------------------------

   assign writeburst_done = idle && writeburst_do && !avm_waitrequest;
   assign readburst_done  = state == READ && counter == '0 && avm_readdatavalid;

   // Last beat comes straight from the bus
   assign readburst_data =
      (save_readburst == 2'd1) ? {avm_readdata, avm_readdata, avm_readdata} :
      (save_readburst == 2'd2) ? {avm_readdata, avm_readdata, rd_last_m1} :
                                 {avm_readdata, rd_last_m1, rd_last_m2};

   assign readcode_partial = avm_readdata;
   assign readcode_beat    = state == READ_CODE && avm_readdatavalid;
   assign readcode_done    = readcode_beat && counter == '0;

   assign dma_readdata      = avm_readdata;
   assign dma_readdatavalid = state == READ_DMA && avm_readdatavalid;
   assign dma_waitrequest   = state != READ_DMA && state != WRITE_DMA;

   // ------------------------------
   // FSM
   // ------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state          <= IDLE;
         counter        <= '0;
         save_readburst <= '0;
      end else begin
         case (state)
            IDLE: begin
               // Nothing starts while the memory stalls
               if (!avm_waitrequest) begin
                  if (writeburst_do) begin
                     if (writeburst_dword_length > 2'd1) begin
                        state <= WRITE;
                     end
                  end else if (sel_rd) begin
                     state          <= READ;
                     counter        <= CNT_W'(readburst_dword_length - 2'd1);
                     save_readburst <= readburst_dword_length;
                  end else if (sel_code) begin
                     state   <= READ_CODE;
                     counter <= CNT_W'(`MEM_CODE_BURST - 1);
                  end else if (sel_dma_wr) begin
                     state <= WRITE_DMA;
                  end else if (sel_dma_rd) begin
                     state <= READ_DMA;
                  end
               end
            end
            WRITE: begin
               if (!avm_waitrequest) begin
                  state <= IDLE;
               end
            end
            READ, READ_CODE: begin
               // Count beats down to the last one
               if (avm_readdatavalid) begin
                  counter <= counter - CNT_W'(1);
                  if (counter == '0) begin
                     state <= IDLE;
                  end
               end
            end
            // One cycle to release the DMA master after its write
            WRITE_DMA: state <= IDLE;
            READ_DMA: begin
               if (avm_readdatavalid) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ------------------------------
   // Payload capture
   // ------------------------------

   always_ff @(posedge clk) begin
      // Second dword zero-extended from the 24 upper bits
      if (idle && !avm_waitrequest && writeburst_do) begin
         save_data       <= {8'd0, writeburst_data[55:32]};
         byteenable_next <= writeburst_byteenable_1;
         writeaddr_next  <= writeburst_address[31:2] + 30'd1;
      end
      if (state == READ && avm_readdatavalid) begin
         if (counter == CNT_W'(2)) begin
            rd_last_m2 <= avm_readdata;
         end
         if (counter == CNT_W'(1)) begin
            rd_last_m1 <= avm_readdata;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/code_line_fill.sv ====
// Code line assembly from the partial dwords of one code fetch
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_config.svh"

module code_line_fill (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   readcode_do,
   input  avm_pkg::avm_data_t     readcode_partial,
   input  logic                   readcode_beat,
   input  logic                   readcode_done,
   output cpu_req_pkg::code_line_t code_line,
   output logic                   code_line_valid
);

   import cpu_req_pkg::*;

   localparam int IDX_W = $clog2(`MEM_CODE_BURST);

   // ------------------------------
   // State
   // ------------------------------

   // Fetch seen but not yet finished
   logic             fetch_active;
   logic [IDX_W-1:0] wr_idx;
   logic             fetch_start;
   code_line_t       line_q;

   // New fetch including one requested right after the last
   assign fetch_start = readcode_do && !fetch_active;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_active    <= 1'b0;
         wr_idx          <= '0;
         code_line_valid <= 1'b0;
      end else begin
         // Line complete one cycle after the last beat
         code_line_valid <= readcode_done;
         if (readcode_done) begin
            fetch_active <= 1'b0;
         end else if (fetch_start) begin
            fetch_active <= 1'b1;
         end
         if (fetch_start) begin
            wr_idx <= '0;
         end else if (readcode_beat) begin
            wr_idx <= wr_idx + IDX_W'(1);
         end
      end
   end

   // Word 0 arrives first
   always_ff @(posedge clk) begin
      if (readcode_beat) begin
         line_q[wr_idx] <= readcode_partial;
      end
   end

   assign code_line = line_q;

endmodule

`default_nettype wire

// ==== verilog/mem_bus_top.sv ====
// Top level joining the Avalon bridge and the code line fill block
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_config.svh"

module mem_bus_top (
   input  logic                          clk,
   input  logic                          rst_n,

   // Core write burst
   input  logic                          writeburst_do,
   output logic                          writeburst_done,
   input  logic [31:0]                   writeburst_address,
   input  cpu_req_pkg::dword_len_t       writeburst_dword_length,
   input  avm_pkg::avm_be_t              writeburst_byteenable_0,
   input  avm_pkg::avm_be_t              writeburst_byteenable_1,
   input  logic [55:0]                   writeburst_data,

   // Core read burst
   input  logic                          readburst_do,
   output logic                          readburst_done,
   input  logic [31:0]                   readburst_address,
   input  cpu_req_pkg::dword_len_t       readburst_dword_length,
   input  cpu_req_pkg::byte_len_t        readburst_byte_length,
   output logic [32*`MEM_RD_MAX_DW-1:0]  readburst_data,

   // Core code fetch
   input  logic                          readcode_do,
   output logic                          readcode_done,
   input  logic [31:0]                   readcode_address,
   output avm_pkg::avm_data_t            readcode_partial,
   output cpu_req_pkg::code_line_t       code_line,
   output logic                          code_line_valid,

   // Avalon master
   output avm_pkg::avm_addr_t            avm_address,
   output avm_pkg::avm_data_t            avm_writedata,
   output avm_pkg::avm_be_t              avm_byteenable,
   output avm_pkg::avm_burst_t           avm_burstcount,
   output logic                          avm_write,
   output logic                          avm_read,
   input  logic                          avm_waitrequest,
   input  logic                          avm_readdatavalid,
   input  avm_pkg::avm_data_t            avm_readdata,

   // DMA slave
   input  logic [`MEM_DMA_ADDR_W-1:0]    dma_address,
   input  logic                          dma_write,
   input  avm_pkg::avm_data_t            dma_writedata,
   input  avm_pkg::avm_be_t              dma_byteenable,
   input  logic                          dma_read,
   output avm_pkg::avm_data_t            dma_readdata,
   output logic                          dma_readdatavalid,
   output logic                          dma_waitrequest
);

   // Code beat strobe, bridge to line fill only
   logic readcode_beat;

   // ------------------------------
   // Bridge
   // ------------------------------

   avalon_mem u_bridge (
      .clk                     (clk),
      .rst_n                   (rst_n),
      .writeburst_do           (writeburst_do),
      .writeburst_done         (writeburst_done),
      .writeburst_address      (writeburst_address),
      .writeburst_dword_length (writeburst_dword_length),
      .writeburst_byteenable_0 (writeburst_byteenable_0),
      .writeburst_byteenable_1 (writeburst_byteenable_1),
      .writeburst_data         (writeburst_data),
      .readburst_do            (readburst_do),
      .readburst_done          (readburst_done),
      .readburst_address       (readburst_address),
      .readburst_dword_length  (readburst_dword_length),
      .readburst_byte_length   (readburst_byte_length),
      .readburst_data          (readburst_data),
      .readcode_do             (readcode_do),
      .readcode_done           (readcode_done),
      .readcode_address        (readcode_address),
      .readcode_partial        (readcode_partial),
      .readcode_beat           (readcode_beat),
      .avm_address             (avm_address),
      .avm_writedata           (avm_writedata),
      .avm_byteenable          (avm_byteenable),
      .avm_burstcount          (avm_burstcount),
      .avm_write               (avm_write),
      .avm_read                (avm_read),
      .avm_waitrequest         (avm_waitrequest),
      .avm_readdatavalid       (avm_readdatavalid),
      .avm_readdata            (avm_readdata),
      .dma_address             (dma_address),
      .dma_write               (dma_write),
      .dma_writedata           (dma_writedata),
      .dma_byteenable          (dma_byteenable),
      .dma_read                (dma_read),
      .dma_readdata            (dma_readdata),
      .dma_readdatavalid       (dma_readdatavalid),
      .dma_waitrequest         (dma_waitrequest)
   );

   // ------------------------------
   // Code line
   // ------------------------------

   code_line_fill u_line_fill (
      .clk              (clk),
      .rst_n            (rst_n),
      .readcode_do      (readcode_do),
      .readcode_partial (readcode_partial),
      .readcode_beat    (readcode_beat),
      .readcode_done    (readcode_done),
      .code_line        (code_line),
      .code_line_valid  (code_line_valid)
   );

endmodule

`default_nettype wire

// ==== tests/avalon_slave_model.sv ====
// Behavioral Avalon-MM memory with burst reads, random waitrequest and read latency
`timescale 1ns/100ps
`default_nettype none

module avalon_slave_model #(
   parameter int WAIT_PCT = 30,
   parameter int MAX_LAT  = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  avm_pkg::avm_addr_t  avm_address,
   input  avm_pkg::avm_data_t  avm_writedata,
   input  avm_pkg::avm_be_t    avm_byteenable,
   input  avm_pkg::avm_burst_t avm_burstcount,
   input  logic                avm_write,
   input  logic                avm_read,
   output logic                avm_waitrequest,
   output logic                avm_readdatavalid,
   output avm_pkg::avm_data_t  avm_readdata
);

   // 1024 dwords, low address bits only
   logic [31:0] mem [0:1023];
   logic [9:0]  rd_addr;
   int          rd_left;
   int          lat;

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = '0;
      end
      avm_readdata = '0;
   end

   // ------------------------------
   // Command and response
   // ------------------------------

   always @(posedge clk) begin
      if (!rst_n) begin
         avm_waitrequest   <= 1'b1;
         avm_readdatavalid <= 1'b0;
         rd_left           <= 0;
         lat               <= 0;
      end else begin
         avm_readdatavalid <= 1'b0;
         // New stall decision every cycle
         avm_waitrequest   <= (($urandom % 100) < WAIT_PCT);
         if (avm_write && !avm_waitrequest) begin
            for (int b = 0; b < 4; b++) begin
               if (avm_byteenable[b]) begin
                  mem[avm_address[11:2]][8*b +: 8] <= avm_writedata[8*b +: 8];
               end
            end
         end
         if (avm_read && !avm_waitrequest) begin
            rd_addr <= avm_address[11:2];
            rd_left <= int'(avm_burstcount);
            lat     <= int'($urandom % MAX_LAT);
         end else if (rd_left > 0) begin
            if (lat > 0) begin
               lat <= lat - 1;
            end else begin
               // One beat, then a short random gap
               avm_readdatavalid <= 1'b1;
               avm_readdata      <= mem[rd_addr];
               rd_addr           <= rd_addr + 10'd1;
               rd_left           <= rd_left - 1;
               lat               <= int'($urandom % 2);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_mem_bus.sv ====
// Testbench for mem_bus_top with clock, reset, operation table, shadow memory and checks
`timescale 1ns/100ps
`default_nettype none

module tb_mem_bus;

   import avm_pkg::*;
   import cpu_req_pkg::*;

   localparam int TIMEOUT = 200;

   typedef enum {K_WR, K_RD, K_CODE, K_DMA_WR, K_DMA_RD, K_PRIO} op_kind_t;

   // One operation of the table
   typedef struct {
      op_kind_t    kind;
      logic [31:0] addr;
      logic [1:0]  len;
      logic [3:0]  blen;
      logic [3:0]  be0;
      logic [3:0]  be1;
      logic [55:0] data;
      logic        has_exp;
      logic [95:0] exp;
   } op_t;

   logic clk;
   logic rst_n;
   logic writeburst_do, writeburst_done;
   logic [31:0] writeburst_address;
   dword_len_t writeburst_dword_length;
   avm_be_t writeburst_byteenable_0, writeburst_byteenable_1;
   logic [55:0] writeburst_data;
   logic readburst_do, readburst_done;
   logic [31:0] readburst_address;
   dword_len_t readburst_dword_length;
   byte_len_t readburst_byte_length;
   logic [95:0] readburst_data;
   logic readcode_do, readcode_done;
   logic [31:0] readcode_address;
   avm_data_t readcode_partial;
   code_line_t code_line;
   logic code_line_valid;
   avm_addr_t avm_address;
   avm_data_t avm_writedata, avm_readdata;
   avm_be_t avm_byteenable;
   avm_burst_t avm_burstcount;
   logic avm_write, avm_read, avm_waitrequest, avm_readdatavalid;
   logic [23:0] dma_address;
   logic dma_write, dma_read, dma_readdatavalid, dma_waitrequest;
   avm_data_t dma_writedata, dma_readdata;
   avm_be_t dma_byteenable;

   logic [31:0] shadow [0:1023];
   op_t         ops [$];

   mem_bus_top DUT (.*);

   avalon_slave_model u_mem (
      .clk(clk), .rst_n(rst_n), .avm_address(avm_address), .avm_writedata(avm_writedata),
      .avm_byteenable(avm_byteenable), .avm_burstcount(avm_burstcount),
      .avm_write(avm_write), .avm_read(avm_read), .avm_waitrequest(avm_waitrequest),
      .avm_readdatavalid(avm_readdatavalid), .avm_readdata(avm_readdata)
   );

   always #10 clk = ~clk;

   // ------------------------------
   // Helpers
   // ------------------------------

   task automatic check(input string name, input logic [255:0] exp, input logic [255:0] got);
      if (exp !== got) begin
         $display("Error %s expected %h actual %h", name, exp, got);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // Wait up to the falling edge and count the cycle against the timeout
   task automatic tick_with_limit(inout int n, input string what);
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
         $display("Timed out waiting for %s", what);
         $display("TEST RESULT: FAIL");
         $fatal(1, "timeout");
      end
   endtask

   task automatic shadow_write(input logic [9:0] a, input logic [3:0] be, input logic [31:0] d);
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            shadow[a][8*b +: 8] = d[8*b +: 8];
         end
      end
   endtask

   // Read burst result built from consecutive shadow words
   function automatic logic [95:0] burst_expect(input logic [9:0] a, input logic [1:0] len);
      logic [31:0] w0;
      logic [31:0] w1;
      logic [31:0] w2;
      w0 = shadow[a];
      w1 = shadow[a + 10'd1];
      w2 = shadow[a + 10'd2];
      if (len == 2'd1) begin
         return {w0, w0, w0};
      end else if (len == 2'd2) begin
         return {w1, w1, w0};
      end
      return {w2, w1, w0};
   endfunction

   function automatic op_t row(input op_kind_t k, input logic [31:0] a, input logic [1:0] len,
                               input logic [3:0] blen, input logic [3:0] be0,
                               input logic [3:0] be1, input logic [55:0] d,
                               input logic he, input logic [95:0] e);
      op_t o;
      o.kind = k;
      o.addr = a;
      o.len = len;
      o.blen = blen;
      o.be0 = be0;
      o.be1 = be1;
      o.data = d;
      o.has_exp = he;
      o.exp = e;
      return o;
   endfunction

   // ------------------------------
   // Operation table
   // ------------------------------

   task automatic load_table();
      ops.push_back(row(K_WR, 32'h40, 2'd1, 4'd4, 4'hf, 4'h0, 56'h0000001111_2222, 0, '0));
      ops.push_back(row(K_WR, 32'h44, 2'd2, 4'd8, 4'hc, 4'h7, 56'habcdef_87654321, 0, '0));
      ops.push_back(row(K_RD, 32'h44, 2'd2, 4'd8, 4'h0, 4'h0, '0, 1,
                        96'h00abcdef_00abcdef_87650000));
      ops.push_back(row(K_RD, 32'h40, 2'd3, 4'd12, 4'h0, 4'h0, '0, 1,
                        96'h00abcdef_87650000_11112222));
      ops.push_back(row(K_RD, 32'h42, 2'd1, 4'd2, 4'h0, 4'h0, '0, 1,
                        96'h11112222_11112222_11112222));
      ops.push_back(row(K_CODE, 32'h40, 2'd0, 4'd0, 4'h0, 4'h0, '0, 0, '0));
      ops.push_back(row(K_DMA_WR, 32'h200, 2'd1, 4'd4, 4'h6, 4'h0, 56'h12345678, 0, '0));
      ops.push_back(row(K_DMA_RD, 32'h200, 2'd1, 4'd4, 4'h0, 4'h0, '0, 1, 96'h00345600));
      ops.push_back(row(K_RD, 32'h200, 2'd1, 4'd4, 4'h0, 4'h0, '0, 1,
                        96'h00345600_00345600_00345600));
      ops.push_back(row(K_PRIO, 32'h300, 2'd1, 4'd4, 4'hf, 4'h0, 56'ha5a55a5a, 1, 96'ha5a55a5a));
      ops.push_back(row(K_CODE, 32'h1f0, 2'd0, 4'd0, 4'h0, 4'h0, '0, 0, '0));
   endtask

   task automatic run_op(input int i);
      op_t o;
      string nm;
      int n;
      int vcount;
      logic [95:0] got;
      logic [255:0] line_exp;
      logic [9:0] a;
      o = ops[i];
      nm = $sformatf("op%0d_%s", i, o.kind.name());
      a = o.addr[11:2];
      n = 0;
      @(posedge clk);
      case (o.kind)
         K_WR, K_PRIO: begin
            writeburst_do <= 1'b1;
            writeburst_address <= o.addr;
            writeburst_dword_length <= o.len;
            writeburst_byteenable_0 <= o.be0;
            writeburst_byteenable_1 <= o.be1;
            writeburst_data <= o.data;
            if (o.kind == K_PRIO) begin
               dma_read <= 1'b1;
               dma_address <= o.addr[23:0];
            end
            // DMA must stay stalled until the write is accepted
            do begin
               tick_with_limit(n, "writeburst_done");
               if (o.kind == K_PRIO) begin
                  check({nm, "_dma_hold"}, 256'd1, {255'd0, dma_waitrequest});
               end
            end while (!writeburst_done);
            @(posedge clk);
            writeburst_do <= 1'b0;
            shadow_write(a, o.be0, o.data[31:0]);
            if (o.len == 2'd2) begin
               shadow_write(a + 10'd1, o.be1, {8'd0, o.data[55:32]});
            end
            if (o.kind == K_PRIO) begin
               n = 0;
               do tick_with_limit(n, "dma_readdatavalid"); while (!dma_readdatavalid);
               got = {64'd0, dma_readdata};
               @(posedge clk);
               dma_read <= 1'b0;
               check(nm, {160'd0, 64'd0, shadow[a]}, {160'd0, got});
               check({nm, "_table"}, {160'd0, o.exp}, {160'd0, got});
            end
         end
         K_RD: begin
            readburst_do <= 1'b1;
            readburst_address <= o.addr;
            readburst_dword_length <= o.len;
            readburst_byte_length <= o.blen;
            do tick_with_limit(n, "readburst_done"); while (!readburst_done);
            got = readburst_data;
            @(posedge clk);
            readburst_do <= 1'b0;
            check(nm, {160'd0, burst_expect(a, o.len)}, {160'd0, got});
            if (o.has_exp) begin
               check({nm, "_table"}, {160'd0, o.exp}, {160'd0, got});
            end
         end
         K_CODE: begin
            readcode_do <= 1'b1;
            readcode_address <= o.addr;
            do tick_with_limit(n, "readcode_done"); while (!readcode_done);
            // Eighth word still on the partial bus
            check({nm, "_partial"}, {224'd0, shadow[a + 10'd7]}, {224'd0, readcode_partial});
            @(posedge clk);
            readcode_do <= 1'b0;
            n = 0;
            do tick_with_limit(n, "code_line_valid"); while (!code_line_valid);
            for (int k = 0; k < 8; k++) begin
               line_exp[32*k +: 32] = shadow[a + 10'(k)];
            end
            check(nm, line_exp, code_line);
            // Valid is a single pulse
            vcount = 0;
            repeat (8) begin
               @(negedge clk);
               vcount += int'(code_line_valid);
            end
            check({nm, "_valid_once"}, 256'd0, 256'(vcount));
         end
         K_DMA_WR: begin
            dma_write <= 1'b1;
            dma_address <= o.addr[23:0];
            dma_writedata <= o.data[31:0];
            dma_byteenable <= o.be0;
            do tick_with_limit(n, "dma write accept"); while (dma_waitrequest);
            @(posedge clk);
            dma_write <= 1'b0;
            shadow_write(a, o.be0, o.data[31:0]);
         end
         default: begin
            dma_read <= 1'b1;
            dma_address <= o.addr[23:0];
            do tick_with_limit(n, "dma_readdatavalid"); while (!dma_readdatavalid);
            got = {64'd0, dma_readdata};
            @(posedge clk);
            dma_read <= 1'b0;
            check(nm, {160'd0, 64'd0, shadow[a]}, {160'd0, got});
            if (o.has_exp) begin
               check({nm, "_table"}, {160'd0, o.exp}, {160'd0, got});
            end
         end
      endcase
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------

   initial begin
      void'($urandom(32'hb30e70b4));
      for (int i = 0; i < 1024; i++) begin
         shadow[i] = '0;
      end
      clk = 1'b0;
      rst_n <= 1'b0;
      writeburst_do <= 1'b0;
      writeburst_address <= '0;
      writeburst_dword_length <= '0;
      writeburst_byteenable_0 <= '0;
      writeburst_byteenable_1 <= '0;
      writeburst_data <= '0;
      readburst_do <= 1'b0;
      readburst_address <= '0;
      readburst_dword_length <= '0;
      readburst_byte_length <= '0;
      readcode_do <= 1'b0;
      readcode_address <= '0;
      dma_address <= '0;
      dma_write <= 1'b0;
      dma_writedata <= '0;
      dma_byteenable <= '0;
      dma_read <= 1'b0;
      load_table();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      // Outputs idle right after reset
      check("reset_outputs", 256'b0100000,
            {249'd0, avm_write, dma_waitrequest, avm_read, writeburst_done,
             readburst_done, readcode_done, code_line_valid});
      for (int i = 0; i < ops.size(); i++) begin
         run_op(i);
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/avm_pkg.sv
verilog/cpu_req_pkg.sv
verilog/avalon_mem.sv
verilog/code_line_fill.sv
verilog/mem_bus_top.sv
tests/avalon_slave_model.sv
tests/tb_mem_bus.sv

// ==== Makefile ====
# Verilator build and run of the mem_bus testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_bus
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TEST RESULT: PASS

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_TEXT)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
